//--- build.f
+incdir+verification
logic/filter_cfg_pkg.sv
logic/cfg_write_decode.sv
logic/commit_sequencer.sv
logic/commit_bank.sv
logic/filter_cfg_top.sv
verification/tb_filter_cfg.sv

//--- logic/cfg_write_decode.sv
/*
 * Host write decode
 * Loads the shadow registers from host writes and raises a one-cycle
 * run request on a command write with the start bit set
 */
`timescale 1ns/10ps

module cfg_write_decode
(
    input  logic                                   clk_i,
    input  logic                                   rstn_i,
    input  logic                                   cfg_valid_i,
    input  logic                                   cfg_rwn_i,
    input  logic [filter_cfg_pkg::REG_ADDR_W-1:0]  cfg_addr_i,
    input  logic [filter_cfg_pkg::DATA_W-1:0]      cfg_data_i,
    output logic                                   run_req_o,
    output logic [filter_cfg_pkg::L2_ADDR_W-1:0]   shd_tx_addr_o,
    output logic [filter_cfg_pkg::SIZE_W-1:0]      shd_tx_size_o,
    output logic [filter_cfg_pkg::SIZE_W-1:0]      shd_tx_mode_o,
    output logic [filter_cfg_pkg::TRANS_W-1:0]     shd_tx_len_o,
    output logic [filter_cfg_pkg::L2_ADDR_W-1:0]   shd_rx_addr_o,
    output logic [filter_cfg_pkg::SIZE_W-1:0]      shd_rx_size_o,
    output logic [filter_cfg_pkg::SIZE_W-1:0]      shd_rx_mode_o,
    output logic [filter_cfg_pkg::TRANS_W-1:0]     shd_rx_len_o,
    output logic                                   shd_au_signed_o,
    output logic                                   shd_au_bypass_o,
    output logic [filter_cfg_pkg::AU_MODE_W-1:0]   shd_au_mode_o,
    output logic [filter_cfg_pkg::AU_SHIFT_W-1:0]  shd_au_shift_o,
    output logic [filter_cfg_pkg::DATA_W-1:0]      shd_au_reg0_o,
    output logic [filter_cfg_pkg::DATA_W-1:0]      shd_bincu_th_o,
    output logic [filter_cfg_pkg::TRANS_W-1:0]     shd_bincu_cnt_o,
    output logic                                   shd_bincu_en_o,
    output logic [filter_cfg_pkg::FMODE_W-1:0]     shd_filt_mode_o
);

    import filter_cfg_pkg::*;

    logic      wr_en;
    reg_addr_e wr_addr;

    assign wr_en   = cfg_valid_i & ~cfg_rwn_i;
    assign wr_addr = reg_addr_e'(cfg_addr_i);

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (~rstn_i)
        begin
            run_req_o <= 1'b0;
        end
        else
        begin
            run_req_o <= wr_en && (wr_addr == REG_FILT_CMD) && cfg_data_i[CMD_START_BIT];
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (~rstn_i)
        begin
            shd_tx_addr_o   <= '0;
            shd_tx_size_o   <= '0;
            shd_tx_mode_o   <= '0;
            shd_tx_len_o    <= '0;
            shd_rx_addr_o   <= '0;
            shd_rx_size_o   <= '0;
            shd_rx_mode_o   <= '0;
            shd_rx_len_o    <= '0;
            shd_au_signed_o <= 1'b0;
            shd_au_bypass_o <= 1'b0;
            shd_au_mode_o   <= '0;
            shd_au_shift_o  <= '0;
            shd_au_reg0_o   <= '0;
            shd_bincu_th_o  <= '0;
            shd_bincu_cnt_o <= '0;
            shd_bincu_en_o  <= 1'b0;
            shd_filt_mode_o <= '0;
        end
        else if (wr_en)
        begin
            case (wr_addr)
                REG_TX_ADD: shd_tx_addr_o <= cfg_data_i[L2_ADDR_W-1:0];
                REG_TX_CFG:
                begin
                    shd_tx_size_o <= cfg_data_i[SIZE_W-1:0];
                    shd_tx_mode_o <= cfg_data_i[CH_MODE_LSB +: SIZE_W];
                end
                REG_TX_LEN: shd_tx_len_o <= cfg_data_i[TRANS_W-1:0];
                REG_RX_ADD: shd_rx_addr_o <= cfg_data_i[L2_ADDR_W-1:0];
                REG_RX_CFG:
                begin
                    shd_rx_size_o <= cfg_data_i[SIZE_W-1:0];
                    shd_rx_mode_o <= cfg_data_i[CH_MODE_LSB +: SIZE_W];
                end
                REG_RX_LEN: shd_rx_len_o <= cfg_data_i[TRANS_W-1:0];
                REG_AU_CFG:
                begin
                    shd_au_signed_o <= cfg_data_i[AU_SIGNED_BIT];
                    shd_au_bypass_o <= cfg_data_i[AU_BYPASS_BIT];
                    shd_au_mode_o   <= cfg_data_i[AU_MODE_LSB +: AU_MODE_W];
                    shd_au_shift_o  <= cfg_data_i[AU_SHIFT_LSB +: AU_SHIFT_W];
                end
                REG_AU_REG0:   shd_au_reg0_o <= cfg_data_i;
                REG_BINCU_TH:  shd_bincu_th_o <= cfg_data_i;
                REG_BINCU_CNT:
                begin
                    shd_bincu_cnt_o <= cfg_data_i[TRANS_W-1:0];
                    shd_bincu_en_o  <= cfg_data_i[BINCU_EN_BIT];
                end
                REG_FILT:      shd_filt_mode_o <= cfg_data_i[FMODE_W-1:0];
                default:       ;  // Command, live count and holes
            endcase
        end
    end

    // Host spaces its command writes, so a request is always a single pulse
    assert property (@(posedge clk_i) disable iff (!rstn_i) run_req_o |=> !run_req_o)
        else $error("run request held for two cycles");

endmodule

//--- logic/commit_bank.sv
/*
 * Committed register bank
 * Holds the configuration seen by the engine, loaded from the shadow
 * set on commit, and serves host reads from it
 */
`timescale 1ns/10ps

module commit_bank
(
    input  logic                                   clk_i,
    input  logic                                   rstn_i,
    input  logic                                   commit_i,
    input  logic [filter_cfg_pkg::L2_ADDR_W-1:0]   shd_tx_addr_i,
    input  logic [filter_cfg_pkg::SIZE_W-1:0]      shd_tx_size_i,
    input  logic [filter_cfg_pkg::SIZE_W-1:0]      shd_tx_mode_i,
    input  logic [filter_cfg_pkg::TRANS_W-1:0]     shd_tx_len_i,
    input  logic [filter_cfg_pkg::L2_ADDR_W-1:0]   shd_rx_addr_i,
    input  logic [filter_cfg_pkg::SIZE_W-1:0]      shd_rx_size_i,
    input  logic [filter_cfg_pkg::SIZE_W-1:0]      shd_rx_mode_i,
    input  logic [filter_cfg_pkg::TRANS_W-1:0]     shd_rx_len_i,
    input  logic                                   shd_au_signed_i,
    input  logic                                   shd_au_bypass_i,
    input  logic [filter_cfg_pkg::AU_MODE_W-1:0]   shd_au_mode_i,
    input  logic [filter_cfg_pkg::AU_SHIFT_W-1:0]  shd_au_shift_i,
    input  logic [filter_cfg_pkg::DATA_W-1:0]      shd_au_reg0_i,
    input  logic [filter_cfg_pkg::DATA_W-1:0]      shd_bincu_th_i,
    input  logic [filter_cfg_pkg::TRANS_W-1:0]     shd_bincu_cnt_i,
    input  logic                                   shd_bincu_en_i,
    input  logic [filter_cfg_pkg::FMODE_W-1:0]     shd_filt_mode_i,
    input  logic                                   cfg_valid_i,
    input  logic                                   cfg_rwn_i,
    input  logic [filter_cfg_pkg::REG_ADDR_W-1:0]  cfg_addr_i,
    input  logic [filter_cfg_pkg::TRANS_W-1:0]     bincu_count_i,
    output logic [filter_cfg_pkg::DATA_W-1:0]      cfg_data_o,
    output logic [filter_cfg_pkg::L2_ADDR_W-1:0]   cfg_tx_addr_o,
    output logic [filter_cfg_pkg::SIZE_W-1:0]      cfg_tx_size_o,
    output logic [filter_cfg_pkg::SIZE_W-1:0]      cfg_tx_mode_o,
    output logic [filter_cfg_pkg::TRANS_W-1:0]     cfg_tx_len_o,
    output logic [filter_cfg_pkg::L2_ADDR_W-1:0]   cfg_rx_addr_o,
    output logic [filter_cfg_pkg::SIZE_W-1:0]      cfg_rx_size_o,
    output logic [filter_cfg_pkg::SIZE_W-1:0]      cfg_rx_mode_o,
    output logic [filter_cfg_pkg::TRANS_W-1:0]     cfg_rx_len_o,
    output logic                                   cfg_au_signed_o,
    output logic                                   cfg_au_bypass_o,
    output logic [filter_cfg_pkg::AU_MODE_W-1:0]   cfg_au_mode_o,
    output logic [filter_cfg_pkg::AU_SHIFT_W-1:0]  cfg_au_shift_o,
    output logic [filter_cfg_pkg::DATA_W-1:0]      cfg_au_reg0_o,
    output logic [filter_cfg_pkg::DATA_W-1:0]      cfg_bincu_th_o,
    output logic [filter_cfg_pkg::TRANS_W-1:0]     cfg_bincu_cnt_o,
    output logic                                   cfg_bincu_en_o,
    output logic [filter_cfg_pkg::FMODE_W-1:0]     cfg_filt_mode_o
);

    import filter_cfg_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Committed set, outputs come straight from the flops
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (~rstn_i)
        begin
            cfg_tx_addr_o   <= '0;
            cfg_tx_size_o   <= '0;
            cfg_tx_mode_o   <= '0;
            cfg_tx_len_o    <= '0;
            cfg_rx_addr_o   <= '0;
            cfg_rx_size_o   <= '0;
            cfg_rx_mode_o   <= '0;
            cfg_rx_len_o    <= '0;
            cfg_au_signed_o <= 1'b0;
            cfg_au_bypass_o <= 1'b0;
            cfg_au_mode_o   <= '0;
            cfg_au_shift_o  <= '0;
            cfg_au_reg0_o   <= '0;
            cfg_bincu_th_o  <= '0;
            cfg_bincu_cnt_o <= '0;
            cfg_bincu_en_o  <= 1'b0;
            cfg_filt_mode_o <= '0;
        end
        else if (commit_i)
        begin
            cfg_tx_addr_o   <= shd_tx_addr_i;
            cfg_tx_size_o   <= shd_tx_size_i;
            cfg_tx_mode_o   <= shd_tx_mode_i;
            cfg_tx_len_o    <= shd_tx_len_i;
            cfg_rx_addr_o   <= shd_rx_addr_i;
            cfg_rx_size_o   <= shd_rx_size_i;
            cfg_rx_mode_o   <= shd_rx_mode_i;
            cfg_rx_len_o    <= shd_rx_len_i;
            cfg_au_signed_o <= shd_au_signed_i;
            cfg_au_bypass_o <= shd_au_bypass_i;
            cfg_au_mode_o   <= shd_au_mode_i;
            cfg_au_shift_o  <= shd_au_shift_i;
            cfg_au_reg0_o   <= shd_au_reg0_i;
            cfg_bincu_th_o  <= shd_bincu_th_i;
            cfg_bincu_cnt_o <= shd_bincu_cnt_i;
            cfg_bincu_en_o  <= shd_bincu_en_i;
            cfg_filt_mode_o <= shd_filt_mode_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Host readback
    //////////////////////////////////////////////////////////////////////
    always_comb
    begin
        cfg_data_o = '0;
        if (cfg_valid_i && cfg_rwn_i)
        begin
            case (reg_addr_e'(cfg_addr_i))
                REG_TX_ADD: cfg_data_o[L2_ADDR_W-1:0] = cfg_tx_addr_o;
                REG_TX_CFG:
                begin
                    cfg_data_o[SIZE_W-1:0]            = cfg_tx_size_o;
                    cfg_data_o[CH_MODE_LSB +: SIZE_W] = cfg_tx_mode_o;
                end
                REG_TX_LEN: cfg_data_o[TRANS_W-1:0] = cfg_tx_len_o;
                REG_RX_ADD: cfg_data_o[L2_ADDR_W-1:0] = cfg_rx_addr_o;
                REG_RX_CFG:
                begin
                    cfg_data_o[SIZE_W-1:0]            = cfg_rx_size_o;
                    cfg_data_o[CH_MODE_LSB +: SIZE_W] = cfg_rx_mode_o;
                end
                REG_RX_LEN: cfg_data_o[TRANS_W-1:0] = cfg_rx_len_o;
                REG_AU_CFG:
                begin
                    cfg_data_o[AU_SIGNED_BIT]              = cfg_au_signed_o;
                    cfg_data_o[AU_BYPASS_BIT]              = cfg_au_bypass_o;
                    cfg_data_o[AU_MODE_LSB +: AU_MODE_W]   = cfg_au_mode_o;
                    cfg_data_o[AU_SHIFT_LSB +: AU_SHIFT_W] = cfg_au_shift_o;
                end
                REG_AU_REG0:   cfg_data_o = cfg_au_reg0_o;
                REG_BINCU_TH:  cfg_data_o = cfg_bincu_th_o;
                REG_BINCU_CNT:
                begin
                    cfg_data_o[TRANS_W-1:0]  = cfg_bincu_cnt_o;
                    cfg_data_o[BINCU_EN_BIT] = cfg_bincu_en_o;
                end
                REG_BINCU_VAL: cfg_data_o[TRANS_W-1:0] = bincu_count_i;  // Live count
                REG_FILT:      cfg_data_o[FMODE_W-1:0] = cfg_filt_mode_o;
                default:       cfg_data_o = '0;
            endcase
        end
    end

endmodule

//--- logic/commit_sequencer.sv
/*
 * Commit sequencer
 * Copies the shadow set into the committed set on a run request and
 * issues the engine start, holding one pending request while busy
 */
`timescale 1ns/10ps

module commit_sequencer
(
    input  logic clk_i,
    input  logic rstn_i,
    input  logic run_req_i,
    input  logic filter_done_i,
    output logic commit_o,
    output logic cfg_filter_start_o
);

    import filter_cfg_pkg::*;

    seq_state_e state_q;
    seq_state_e state_d;
    logic       pending_q;
    logic       pending_d;

    always_comb
    begin
        state_d   = state_q;
        pending_d = pending_q;
        commit_o  = 1'b0;
        case (state_q)
            ST_IDLE:
            begin
                if (run_req_i)
                begin
                    commit_o = 1'b1;
                    state_d  = ST_SAMPLE;
                end
            end
            ST_SAMPLE:
            begin
                state_d = ST_BUSY;
                if (run_req_i)
                begin
                    pending_d = 1'b1;  // Engine already owns this run
                end
            end
            ST_BUSY:
            begin
                if (filter_done_i && (run_req_i || pending_q))
                begin
                    commit_o  = 1'b1;
                    pending_d = 1'b0;
                    state_d   = ST_SAMPLE;
                end
                else if (filter_done_i)
                begin
                    state_d = ST_IDLE;
                end
                else if (run_req_i)
                begin
                    pending_d = 1'b1;  // Collapses repeats
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (~rstn_i)
        begin
            state_q   <= ST_IDLE;
            pending_q <= 1'b0;
        end
        else
        begin
            state_q   <= state_d;
            pending_q <= pending_d;
        end
    end

    assign cfg_filter_start_o = (state_q == ST_SAMPLE);

    assert property (@(posedge clk_i) disable iff (!rstn_i) commit_o |=> cfg_filter_start_o)
        else $error("commit not followed by start");
    assert property (@(posedge clk_i) disable iff (!rstn_i)
                     cfg_filter_start_o |=> !cfg_filter_start_o)
        else $error("start strobe held for two cycles");

endmodule

//--- logic/filter_cfg_pkg.sv
/*
 * Filter configuration package
 * Widths, host register map, field positions and the commit
 * sequencer states shared by the configuration register block
 */
package filter_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////
    localparam int unsigned DATA_W     = 32;  // Host data bus
    localparam int unsigned REG_ADDR_W = 5;   // Word address
    localparam int unsigned L2_ADDR_W  = 15;  // Channel start address
    localparam int unsigned TRANS_W    = 16;  // Lengths and counts
    localparam int unsigned SIZE_W     = 2;
    localparam int unsigned FMODE_W    = 4;
    localparam int unsigned AU_MODE_W  = 4;
    localparam int unsigned AU_SHIFT_W = 5;

    //////////////////////////////////////////////////////////////////////
    // Field positions inside the register words
    //////////////////////////////////////////////////////////////////////
    localparam int unsigned CH_MODE_LSB   = 8;   // Channel cfg, size sits at bit 0
    localparam int unsigned AU_SIGNED_BIT = 0;
    localparam int unsigned AU_BYPASS_BIT = 1;
    localparam int unsigned AU_MODE_LSB   = 8;
    localparam int unsigned AU_SHIFT_LSB  = 16;
    localparam int unsigned BINCU_EN_BIT  = 31;  // Counter preset enable
    localparam int unsigned CMD_START_BIT = 0;

    //////////////////////////////////////////////////////////////////////
    // Register map, word offsets
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [REG_ADDR_W-1:0] {
        REG_TX_ADD    = 5'd0,   // 0x00
        REG_TX_CFG    = 5'd1,   // 0x04
        REG_TX_LEN    = 5'd2,   // 0x08
        REG_RX_ADD    = 5'd10,  // 0x28
        REG_RX_CFG    = 5'd11,  // 0x2C
        REG_RX_LEN    = 5'd12,  // 0x30
        REG_AU_CFG    = 5'd15,  // 0x3C
        REG_AU_REG0   = 5'd16,  // 0x40
        REG_BINCU_TH  = 5'd18,  // 0x48
        REG_BINCU_CNT = 5'd19,  // 0x4C
        REG_BINCU_VAL = 5'd21,  // 0x54, read only
        REG_FILT      = 5'd22,  // 0x58
        REG_FILT_CMD  = 5'd23   // 0x5C, write only
    } reg_addr_e;

    // Commit sequencer
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SAMPLE,
        ST_BUSY
    } seq_state_e;

endpackage

//--- logic/filter_cfg_top.sv
/*
 * Filter configuration register block
 * Shadow registers, commit sequencer and committed bank for the
 * streaming filter engine
 */
`timescale 1ns/10ps

module filter_cfg_top
(
    input  logic                                   clk_i,
    input  logic                                   rstn_i,
    input  logic                                   cfg_valid_i,
    input  logic                                   cfg_rwn_i,
    input  logic [filter_cfg_pkg::REG_ADDR_W-1:0]  cfg_addr_i,
    input  logic [filter_cfg_pkg::DATA_W-1:0]      cfg_data_i,
    input  logic                                   filter_done_i,
    input  logic [filter_cfg_pkg::TRANS_W-1:0]     bincu_count_i,
    output logic [filter_cfg_pkg::DATA_W-1:0]      cfg_data_o,
    output logic                                   cfg_filter_start_o,
    output logic [filter_cfg_pkg::L2_ADDR_W-1:0]   cfg_tx_addr_o,
    output logic [filter_cfg_pkg::SIZE_W-1:0]      cfg_tx_size_o,
    output logic [filter_cfg_pkg::SIZE_W-1:0]      cfg_tx_mode_o,
    output logic [filter_cfg_pkg::TRANS_W-1:0]     cfg_tx_len_o,
    output logic [filter_cfg_pkg::L2_ADDR_W-1:0]   cfg_rx_addr_o,
    output logic [filter_cfg_pkg::SIZE_W-1:0]      cfg_rx_size_o,
    output logic [filter_cfg_pkg::SIZE_W-1:0]      cfg_rx_mode_o,
    output logic [filter_cfg_pkg::TRANS_W-1:0]     cfg_rx_len_o,
    output logic                                   cfg_au_signed_o,
    output logic                                   cfg_au_bypass_o,
    output logic [filter_cfg_pkg::AU_MODE_W-1:0]   cfg_au_mode_o,
    output logic [filter_cfg_pkg::AU_SHIFT_W-1:0]  cfg_au_shift_o,
    output logic [filter_cfg_pkg::DATA_W-1:0]      cfg_au_reg0_o,
    output logic [filter_cfg_pkg::DATA_W-1:0]      cfg_bincu_th_o,
    output logic [filter_cfg_pkg::TRANS_W-1:0]     cfg_bincu_cnt_o,
    output logic                                   cfg_bincu_en_o,
    output logic [filter_cfg_pkg::FMODE_W-1:0]     cfg_filt_mode_o
);

    import filter_cfg_pkg::*;

    logic                  run_req;
    logic                  commit;
    logic [L2_ADDR_W-1:0]  shd_tx_addr, shd_rx_addr;
    logic [SIZE_W-1:0]     shd_tx_size, shd_tx_mode, shd_rx_size, shd_rx_mode;
    logic [TRANS_W-1:0]    shd_tx_len, shd_rx_len, shd_bincu_cnt;
    logic                  shd_au_signed, shd_au_bypass, shd_bincu_en;
    logic [AU_MODE_W-1:0]  shd_au_mode;
    logic [AU_SHIFT_W-1:0] shd_au_shift;
    logic [DATA_W-1:0]     shd_au_reg0, shd_bincu_th;
    logic [FMODE_W-1:0]    shd_filt_mode;

    // Input side, host writes into the shadow set
    cfg_write_decode u_write_decode (
        .run_req_o       (run_req),
        .shd_tx_addr_o   (shd_tx_addr),   .shd_tx_size_o   (shd_tx_size),
        .shd_tx_mode_o   (shd_tx_mode),   .shd_tx_len_o    (shd_tx_len),
        .shd_rx_addr_o   (shd_rx_addr),   .shd_rx_size_o   (shd_rx_size),
        .shd_rx_mode_o   (shd_rx_mode),   .shd_rx_len_o    (shd_rx_len),
        .shd_au_signed_o (shd_au_signed), .shd_au_bypass_o (shd_au_bypass),
        .shd_au_mode_o   (shd_au_mode),   .shd_au_shift_o  (shd_au_shift),
        .shd_au_reg0_o   (shd_au_reg0),   .shd_bincu_th_o  (shd_bincu_th),
        .shd_bincu_cnt_o (shd_bincu_cnt), .shd_bincu_en_o  (shd_bincu_en),
        .shd_filt_mode_o (shd_filt_mode),
        .*
    );

    commit_sequencer u_commit_sequencer (
        .run_req_i (run_req),
        .commit_o  (commit),
        .*
    );

    // Output side, committed set and readback
    commit_bank u_commit_bank (
        .commit_i        (commit),
        .shd_tx_addr_i   (shd_tx_addr),   .shd_tx_size_i   (shd_tx_size),
        .shd_tx_mode_i   (shd_tx_mode),   .shd_tx_len_i    (shd_tx_len),
        .shd_rx_addr_i   (shd_rx_addr),   .shd_rx_size_i   (shd_rx_size),
        .shd_rx_mode_i   (shd_rx_mode),   .shd_rx_len_i    (shd_rx_len),
        .shd_au_signed_i (shd_au_signed), .shd_au_bypass_i (shd_au_bypass),
        .shd_au_mode_i   (shd_au_mode),   .shd_au_shift_i  (shd_au_shift),
        .shd_au_reg0_i   (shd_au_reg0),   .shd_bincu_th_i  (shd_bincu_th),
        .shd_bincu_cnt_i (shd_bincu_cnt), .shd_bincu_en_i  (shd_bincu_en),
        .shd_filt_mode_i (shd_filt_mode),
        .*
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile the filter configuration testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f build.f --top-module tb_filter_cfg
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_filter_cfg > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation passed"
exit 0

//--- verification/tb_filter_cfg_model.svh
/*
 * Reference model for the filter configuration testbench
 * Shadow and committed register words, sequencer with pending flag,
 * random source, bus drivers and the value check
 */
`ifndef TB_FILTER_CFG_MODEL_SVH
`define TB_FILTER_CFG_MODEL_SVH

    logic [31:0] rng_state = 32'h6408e0c9;
    logic [31:0] shd_word [0:31] = '{default: '0};  // Register words with unused bits at 0
    logic [31:0] com_word [0:31] = '{default: '0};
    seq_state_e  m_state = ST_IDLE;
    logic        m_pend = 1'b0;
    logic        m_req = 1'b0;      // Request strobe seen by the sequencer
    int unsigned done_wait = 0;

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] low_mask(input int unsigned w);
        logic [63:0] m;
        m = (64'd1 << w) - 64'd1;
        return m[31:0];
    endfunction

    function automatic logic [31:0] field_of(input logic [31:0] word, input int unsigned lsb,
                                             input int unsigned w);
        return (word >> lsb) & low_mask(w);
    endfunction

    // Bits a host write can change
    function automatic logic [31:0] writable_mask(input logic [REG_ADDR_W-1:0] a);
        logic [31:0] m;
        case (a)
            REG_TX_ADD, REG_RX_ADD: m = low_mask(L2_ADDR_W);
            REG_TX_CFG, REG_RX_CFG: m = low_mask(SIZE_W) | (low_mask(SIZE_W) << CH_MODE_LSB);
            REG_TX_LEN, REG_RX_LEN: m = low_mask(TRANS_W);
            REG_AU_CFG:
                m = (32'd1 << AU_SIGNED_BIT) | (32'd1 << AU_BYPASS_BIT)
                    | (low_mask(AU_MODE_W) << AU_MODE_LSB)
                    | (low_mask(AU_SHIFT_W) << AU_SHIFT_LSB);
            REG_AU_REG0, REG_BINCU_TH: m = low_mask(DATA_W);
            REG_BINCU_CNT: m = low_mask(TRANS_W) | (32'd1 << BINCU_EN_BIT);
            REG_FILT:      m = low_mask(FMODE_W);
            default:       m = '0;  // Command, live count, holes
        endcase
        return m;
    endfunction

    function automatic logic [31:0] read_value(input logic [REG_ADDR_W-1:0] a);
        if (a == REG_BINCU_VAL)
            return 32'(bincu_count);
        return com_word[a];
    endfunction

    function automatic logic [REG_ADDR_W-1:0] kept_addr(input logic [31:0] r);
        logic [REG_ADDR_W-1:0] list [0:11];
        logic [3:0]            idx;
        list = '{REG_TX_ADD, REG_TX_CFG, REG_TX_LEN, REG_RX_ADD, REG_RX_CFG, REG_RX_LEN,
                 REG_AU_CFG, REG_AU_REG0, REG_BINCU_TH, REG_BINCU_CNT, REG_BINCU_VAL,
                 REG_FILT};
        idx = 4'(r % 12);
        return list[idx];
    endfunction

    // Start bit set three times out of four
    function automatic logic [31:0] command_word();
        logic [31:0] r;
        r = next_random();
        r[CMD_START_BIT] = (next_random() % 4) != 0;
        return r;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic verify_outputs();
        check_value("filter_start", 32'(start), 32'(m_state == ST_SAMPLE));
        check_value("tx_addr", 32'(tx_addr), com_word[REG_TX_ADD]);
        check_value("tx_size", 32'(tx_size), field_of(com_word[REG_TX_CFG], 0, SIZE_W));
        check_value("tx_mode", 32'(tx_mode), field_of(com_word[REG_TX_CFG], CH_MODE_LSB, SIZE_W));
        check_value("tx_len", 32'(tx_len), com_word[REG_TX_LEN]);
        check_value("rx_addr", 32'(rx_addr), com_word[REG_RX_ADD]);
        check_value("rx_size", 32'(rx_size), field_of(com_word[REG_RX_CFG], 0, SIZE_W));
        check_value("rx_mode", 32'(rx_mode), field_of(com_word[REG_RX_CFG], CH_MODE_LSB, SIZE_W));
        check_value("rx_len", 32'(rx_len), com_word[REG_RX_LEN]);
        check_value("au_signed", 32'(au_signed), field_of(com_word[REG_AU_CFG], AU_SIGNED_BIT, 1));
        check_value("au_bypass", 32'(au_bypass), field_of(com_word[REG_AU_CFG], AU_BYPASS_BIT, 1));
        check_value("au_mode", 32'(au_mode),
                    field_of(com_word[REG_AU_CFG], AU_MODE_LSB, AU_MODE_W));
        check_value("au_shift", 32'(au_shift),
                    field_of(com_word[REG_AU_CFG], AU_SHIFT_LSB, AU_SHIFT_W));
        check_value("au_reg0", au_reg0, com_word[REG_AU_REG0]);
        check_value("bincu_th", bincu_th, com_word[REG_BINCU_TH]);
        check_value("bincu_cnt", 32'(bincu_cnt), field_of(com_word[REG_BINCU_CNT], 0, TRANS_W));
        check_value("bincu_en", 32'(bincu_en), field_of(com_word[REG_BINCU_CNT], BINCU_EN_BIT, 1));
        check_value("filt_mode", 32'(filt_mode), com_word[REG_FILT]);
    endtask

    // Done comes 1 to 8 cycles after each start the DUT gives
    task automatic drive_engine();
        logic [31:0] r;
        done = 1'b0;
        if (done_wait != 0)
        begin
            done_wait = done_wait - 1;
            done      = (done_wait == 0);
        end
        if (start)
            done_wait = 1 + next_random() % 8;
        r           = next_random();
        bincu_count = r[TRANS_W-1:0];
    endtask

    task automatic write_reg(input logic [REG_ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        valid = 1'b1;
        rwn   = 1'b0;
        addr  = a;
        wdata = d;
    endtask

    task automatic read_reg(input logic [REG_ADDR_W-1:0] a);
        valid = 1'b1;
        rwn   = 1'b1;
        addr  = a;
        wdata = '0;
    endtask

    task automatic park_bus();
        valid = 1'b0;
        rwn   = 1'b0;
        addr  = '0;
        wdata = '0;
    endtask

    // Model state at the next rising edge
    task automatic advance_model();
        logic req;
        logic commit;
        req    = m_req;
        commit = 1'b0;
        m_req  = valid && !rwn && (addr == REG_FILT_CMD) && wdata[CMD_START_BIT];
        case (m_state)
            ST_IDLE:
            begin
                if (req)
                begin
                    commit  = 1'b1;
                    m_state = ST_SAMPLE;
                end
            end
            ST_SAMPLE:
            begin
                m_state = ST_BUSY;
                if (req)
                    m_pend = 1'b1;
            end
            default:
            begin
                if (done && (req || m_pend))
                begin
                    commit  = 1'b1;
                    m_pend  = 1'b0;
                    m_state = ST_SAMPLE;
                end
                else if (done)
                    m_state = ST_IDLE;
                else if (req)
                    m_pend = 1'b1;
            end
        endcase
        if (commit)
            com_word = shd_word;  // Shadow as it stood before this cycle's write
        if (valid && !rwn)
            shd_word[addr] = wdata & writable_mask(addr);
    endtask

`endif

//--- verification/tb_filter_cfg.sv
/*
 * Testbench for the filter configuration register block
 * Random host traffic and engine done pulses, checked every cycle
 * against a shadow/committed model with its own commit sequencer
 */
`timescale 1ns/10ps

module tb_filter_cfg;

    import filter_cfg_pkg::*;

    localparam int unsigned NUM_OPS    = 400;
    localparam int unsigned MAX_CYCLES = NUM_OPS * 12;
    localparam int unsigned DRAIN      = 24;  // Enough for one pending run

    logic                  clk;
    logic                  rstn;
    logic                  valid;
    logic                  rwn;
    logic [REG_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     wdata;
    logic                  done;
    logic [TRANS_W-1:0]    bincu_count;
    logic [DATA_W-1:0]     rdata;
    logic                  start;
    logic [L2_ADDR_W-1:0]  tx_addr;
    logic [SIZE_W-1:0]     tx_size;
    logic [SIZE_W-1:0]     tx_mode;
    logic [TRANS_W-1:0]    tx_len;
    logic [L2_ADDR_W-1:0]  rx_addr;
    logic [SIZE_W-1:0]     rx_size;
    logic [SIZE_W-1:0]     rx_mode;
    logic [TRANS_W-1:0]    rx_len;
    logic                  au_signed;
    logic                  au_bypass;
    logic [AU_MODE_W-1:0]  au_mode;
    logic [AU_SHIFT_W-1:0] au_shift;
    logic [DATA_W-1:0]     au_reg0;
    logic [DATA_W-1:0]     bincu_th;
    logic [TRANS_W-1:0]    bincu_cnt;
    logic                  bincu_en;
    logic [FMODE_W-1:0]    filt_mode;
    int unsigned           cycle_count = 0;

    `include "tb_filter_cfg_model.svh"

    filter_cfg_top uut (
        .clk_i           (clk),         .rstn_i          (rstn),
        .cfg_valid_i     (valid),       .cfg_rwn_i       (rwn),
        .cfg_addr_i      (addr),        .cfg_data_i      (wdata),
        .filter_done_i   (done),        .bincu_count_i   (bincu_count),
        .cfg_data_o      (rdata),       .cfg_filter_start_o (start),
        .cfg_tx_addr_o   (tx_addr),     .cfg_tx_size_o   (tx_size),
        .cfg_tx_mode_o   (tx_mode),     .cfg_tx_len_o    (tx_len),
        .cfg_rx_addr_o   (rx_addr),     .cfg_rx_size_o   (rx_size),
        .cfg_rx_mode_o   (rx_mode),     .cfg_rx_len_o    (rx_len),
        .cfg_au_signed_o (au_signed),   .cfg_au_bypass_o (au_bypass),
        .cfg_au_mode_o   (au_mode),     .cfg_au_shift_o  (au_shift),
        .cfg_au_reg0_o   (au_reg0),     .cfg_bincu_th_o  (bincu_th),
        .cfg_bincu_cnt_o (bincu_cnt),   .cfg_bincu_en_o  (bincu_en),
        .cfg_filt_mode_o (filt_mode)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "cycle limit reached");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Outputs checked at the falling edge before new inputs go out
    //////////////////////////////////////////////////////////////////////
    task automatic begin_cycle();
        @(negedge clk);
        verify_outputs();
        drive_engine();
    endtask

    task automatic finish_cycle();
        #1;  // Readback is combinational
        if (valid && rwn)
            check_value("readback", rdata, read_value(addr));
        else
            check_value("idle readback", rdata, 32'd0);
        advance_model();
    endtask

    initial
    begin
        int unsigned op;
        logic        last_cmd;
        logic [31:0] r_addr;
        logic [31:0] r_data;
        clk         = 1'b0;
        rstn        = 1'b0;
        done        = 1'b0;
        bincu_count = '0;
        park_bus();
        last_cmd = 1'b0;
        repeat (5) @(negedge clk);
        rstn = 1'b1;

        // Every address reads 0 out of reset
        for (int a = 0; a < 32; a++)
        begin
            begin_cycle();
            read_reg(REG_ADDR_W'(a));
            finish_cycle();
        end

        for (int i = 0; i < NUM_OPS; i++)
        begin
            begin_cycle();
            op     = next_random() % 4;
            r_addr = next_random();
            r_data = next_random();
            if (op == 2 && last_cmd)
                op = 3;  // No back to back command writes
            case (op)
                0:       write_reg(kept_addr(r_addr), r_data);
                1:       read_reg(r_addr[REG_ADDR_W-1:0]);
                2:       write_reg(REG_FILT_CMD, command_word());
                default: park_bus();
            endcase
            last_cmd = (op == 2);
            finish_cycle();
        end

        // Let the engine finish the last run
        repeat (DRAIN)
        begin
            begin_cycle();
            park_bus();
            finish_cycle();
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule
